// File: kernel_pkg.sv
// ----------------------------------------------------------------------
// Copy kernel shared definitions
// Bus widths, host descriptor, broadcast job and Wishbone classic
// request/response groups, plus the byte-reversal helper used on
// the read data path.
// ----------------------------------------------------------------------

package kernel_pkg;

  // --------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------
  localparam int ADDR_W  = 32;  // Byte address
  localparam int DATA_W  = 32;  // One word per access
  localparam int SEL_W   = 4;   // Byte lanes
  localparam int COUNT_W = 16;  // Words per job

  // Host descriptor, 81 bits
  typedef struct packed {
    logic [ADDR_W-1:0]  src_addr;    // Source base, byte address
    logic [ADDR_W-1:0]  dst_addr;    // Destination base
    logic [COUNT_W-1:0] word_count;  // Zero is legal
    logic               swap_en;     // Byte-reverse each word
  } descriptor_t;

  // Job broadcast to every channel, 82 bits
  typedef struct packed {
    logic        start;  // One-cycle strobe
    descriptor_t desc;
  } job_t;

  // --------------------------------------------------------------------
  // Wishbone classic
  // --------------------------------------------------------------------
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;  // Write data
    logic [SEL_W-1:0]  sel;  // Always all ones here
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] dat;  // Read data, valid with ack
  } wb_rsp_t;

  // Reverse the four bytes of a word
  function automatic logic [DATA_W-1:0] swap_bytes(input logic [DATA_W-1:0] word);
    return {word[7:0], word[15:8], word[23:16], word[31:24]};
  endfunction

endpackage

// File: kernel_control.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Kernel control
// ap_ctrl_chain handshake for the copy kernel. Registers the host
// descriptor on start and broadcasts it with a one-cycle strobe,
// collects the channel done levels and holds ap_done until
// ap_continue. A shift-register pulse then resets the channels.
// ----------------------------------------------------------------------

module kernel_control #(
  parameter int NUM_CHANNELS = 4,
  parameter int PULSE_HOLD   = 8
) (
  input  logic                    ap_clk,
  input  logic                    ap_rst_n,
  input  logic                    ap_start,
  input  logic                    ap_continue,
  input  kernel_pkg::descriptor_t descriptor,
  input  logic [NUM_CHANNELS-1:0] chan_done,
  output logic                    ap_idle,
  output logic                    ap_ready,
  output logic                    ap_done,
  output kernel_pkg::job_t        job,
  output logic                    chan_rst_n
);

  import kernel_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,   // Waiting for ap_start
    S_RUN,    // Channels copying
    S_DONE,   // Holding ap_done for the host
    S_FLUSH   // Channel reset pulse running
  } state_t;

  state_t                state;
  state_t                state_next;
  descriptor_t           desc_q;         // Job descriptor
  logic                  start_q;        // Doubles as ap_ready
  logic [PULSE_HOLD-1:0] pulse_sr;       // Reset stretcher
  logic                  pulse_busy;
  logic                  take_start;
  logic                  take_continue;
  logic                  all_done;

  assign pulse_busy    = pulse_sr[PULSE_HOLD-1];
  assign take_start    = (state == S_IDLE) && ap_start;
  assign take_continue = (state == S_DONE) && ap_continue;
  assign all_done      = &chan_done;  // Every channel finished

  // ----------------------------------------------------------------------
  // State machine
  // ----------------------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      S_IDLE: begin
        if (ap_start)
          state_next = S_RUN;
      end
      S_RUN: begin
        if (all_done)
          state_next = S_DONE;
      end
      S_DONE: begin
        if (ap_continue)
          state_next = S_FLUSH;
      end
      default: begin
        // Back to idle once the pulse has drained
        if (!pulse_busy)
          state_next = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      state   <= S_FLUSH;  // Channels get a full pulse out of reset
      start_q <= 1'b0;
    end else begin
      state   <= state_next;
      start_q <= take_start;  // Single cycle strobe
    end
  end

  // Descriptor captured on the start edge
  always_ff @(posedge ap_clk) begin
    if (take_start)
      desc_q <= descriptor;
  end

  // ----------------------------------------------------------------------
  // Channel reset pulse
  // ----------------------------------------------------------------------
  // Loaded with ones, drained with zeros; MSB is the active reset
  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      pulse_sr <= '1;
    end else if (take_continue) begin
      pulse_sr <= '1;
    end else begin
      pulse_sr <= pulse_sr << 1;
    end
  end

  assign chan_rst_n = ~pulse_busy;

  // Host outputs
  assign ap_idle  = (state == S_IDLE) || (state == S_FLUSH);
  assign ap_ready = start_q;
  assign ap_done  = (state == S_DONE);

  // Job broadcast
  assign job.start = start_q;
  assign job.desc  = desc_q;

endmodule

// File: copy_channel.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Copy channel
// Wishbone classic master that walks word indices CHANNEL_ID,
// CHANNEL_ID+NUM_CHANNELS, ... below the job word count. Each word is
// read, optionally byte-reversed and written back, one at a time.
// ----------------------------------------------------------------------

module copy_channel #(
  parameter int CHANNEL_ID   = 0,
  parameter int NUM_CHANNELS = 4
) (
  input  logic                ap_clk,
  input  logic                ap_rst_n,
  input  logic                chan_rst_n,
  input  kernel_pkg::job_t    job,
  input  kernel_pkg::wb_rsp_t wb_rsp,
  output kernel_pkg::wb_req_t wb_req,
  output logic                done
);

  import kernel_pkg::*;

  localparam int IDX_W = COUNT_W + 1;  // Index may step past the count
  localparam logic [IDX_W-1:0] FIRST_IDX = IDX_W'(CHANNEL_ID);  // This channel's first word

  typedef enum logic [1:0] {
    S_IDLE,  // Waiting for the start strobe
    S_REQ,   // Bus cycle open
    S_GAP,   // Bus released between accesses
    S_DONE   // Held until the channel reset
  } state_t;

  state_t            state;
  logic              we_q;       // Low read phase, high write phase
  logic [IDX_W-1:0]  idx;
  logic [IDX_W-1:0]  idx_next;
  descriptor_t       desc_q;
  logic [DATA_W-1:0] data_q;     // Word in flight
  logic [ADDR_W-1:0] base_addr;
  logic [ADDR_W-1:0] byte_off;

  assign idx_next  = idx + IDX_W'(NUM_CHANNELS);   // Stride over channels
  assign base_addr = we_q ? desc_q.dst_addr : desc_q.src_addr;
  assign byte_off  = ADDR_W'({idx, 2'b00});        // Four bytes per word

  // ----------------------------------------------------------------------
  // Read then write, one word at a time
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      state <= S_IDLE;
      we_q  <= 1'b0;
      idx   <= '0;
    end else if (!chan_rst_n) begin
      state <= S_IDLE;  // Pulse after ap_done clears the channel
      we_q  <= 1'b0;
      idx   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (job.start) begin
            idx  <= FIRST_IDX;
            we_q <= 1'b0;
            // Short jobs may leave this channel without work
            if (FIRST_IDX < {1'b0, job.desc.word_count})
              state <= S_REQ;
            else
              state <= S_DONE;
          end
        end
        S_REQ: begin
          if (wb_rsp.ack) begin
            if (!we_q) begin
              we_q  <= 1'b1;   // Read landed, write next
              state <= S_GAP;
            end else begin
              we_q <= 1'b0;
              idx  <= idx_next;
              if (idx_next < {1'b0, desc_q.word_count})
                state <= S_GAP;
              else
                state <= S_DONE;
            end
          end
        end
        S_GAP:   state <= S_REQ;  // cyc low for one cycle
        default: state <= S_DONE;
      endcase
    end
  end

  // Job and data word registers
  always_ff @(posedge ap_clk) begin
    if ((state == S_IDLE) && job.start)
      desc_q <= job.desc;
    if ((state == S_REQ) && wb_rsp.ack && !we_q)
      data_q <= desc_q.swap_en ? swap_bytes(wb_rsp.dat) : wb_rsp.dat;
  end

  // Bus request
  assign wb_req.cyc = (state == S_REQ);
  assign wb_req.stb = (state == S_REQ);
  assign wb_req.we  = we_q;
  assign wb_req.adr = base_addr + byte_off;
  assign wb_req.dat = data_q;
  assign wb_req.sel = '1;  // Full words only

  assign done = (state == S_DONE);

endmodule

// File: wb_arbiter.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Wishbone round-robin arbiter
// Merges the channel masters onto one classic master port. The grant
// is held for a whole bus cycle and moves on only once the granted
// master drops cyc. Request and response paths are combinational.
// ----------------------------------------------------------------------

module wb_arbiter #(
  parameter int NUM_CHANNELS = 4
) (
  input  logic                ap_clk,
  input  logic                ap_rst_n,
  input  kernel_pkg::wb_req_t chan_req [NUM_CHANNELS],
  input  kernel_pkg::wb_rsp_t port_rsp,
  output kernel_pkg::wb_rsp_t chan_rsp [NUM_CHANNELS],
  output kernel_pkg::wb_req_t port_req
);

  localparam int GNT_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

  logic [GNT_W-1:0] gnt;       // Current owner of the port
  logic [GNT_W-1:0] gnt_next;
  logic [GNT_W-1:0] cand;
  logic             found;
  logic             gnt_busy;

  assign gnt_busy = chan_req[gnt].cyc;  // Owner mid-cycle

  // ----------------------------------------------------------------------
  // Round-robin search
  // ----------------------------------------------------------------------
  // Starts just after the current owner, owner itself checked last
  always_comb begin
    gnt_next = gnt;
    found    = 1'b0;
    cand     = gnt;
    for (int i = 1; i <= NUM_CHANNELS; i++) begin
      cand = GNT_W'((int'(gnt) + i) % NUM_CHANNELS);
      if (!found && chan_req[cand].cyc) begin
        gnt_next = cand;
        found    = 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      gnt <= GNT_W'(NUM_CHANNELS - 1);  // Channel 0 wins first
    end else if (!gnt_busy) begin
      gnt <= gnt_next;  // Only between bus cycles
    end
  end

  // ----------------------------------------------------------------------
  // Port mux and response routing
  // ----------------------------------------------------------------------
  assign port_req = chan_req[gnt];

  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_rsp
    assign chan_rsp[c].ack = port_rsp.ack && (gnt == GNT_W'(c));  // Owner only
    assign chan_rsp[c].dat = port_rsp.dat;  // Broadcast
  end

endmodule

// File: kernel_afu.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Copy kernel top level
// Control block, NUM_CHANNELS copy channels and the Wishbone arbiter
// that drains them onto the single external master port.
// ----------------------------------------------------------------------

module kernel_afu #(
  parameter int NUM_CHANNELS = 4,
  parameter int PULSE_HOLD   = 8
) (
  input  logic                    ap_clk,
  input  logic                    ap_rst_n,
  input  logic                    ap_start,
  input  logic                    ap_continue,
  input  kernel_pkg::descriptor_t descriptor,
  input  kernel_pkg::wb_rsp_t     wb_rsp,
  output logic                    ap_idle,
  output logic                    ap_ready,
  output logic                    ap_done,
  output kernel_pkg::wb_req_t     wb_req
);

  import kernel_pkg::*;

  // ----------------------------------------------------------------------
  // Wires
  // ----------------------------------------------------------------------
  job_t                    job;                     // Broadcast to channels
  logic                    chan_rst_n;              // Pulse after ap_done
  logic [NUM_CHANNELS-1:0] chan_done;
  wb_req_t                 chan_req [NUM_CHANNELS];
  wb_rsp_t                 chan_rsp [NUM_CHANNELS];

  // Host handshake and job broadcast
  kernel_control #(
    .NUM_CHANNELS(NUM_CHANNELS),
    .PULSE_HOLD  (PULSE_HOLD)
  ) inst_kernel_control (
    .ap_clk     (ap_clk),
    .ap_rst_n   (ap_rst_n),
    .ap_start   (ap_start),
    .ap_continue(ap_continue),
    .descriptor (descriptor),
    .chan_done  (chan_done),
    .ap_idle    (ap_idle),
    .ap_ready   (ap_ready),
    .ap_done    (ap_done),
    .job        (job),
    .chan_rst_n (chan_rst_n)
  );

  // ----------------------------------------------------------------------
  // Copy channels, interleaved by word index
  // ----------------------------------------------------------------------
  for (genvar k = 0; k < NUM_CHANNELS; k++) begin : g_channel
    copy_channel #(
      .CHANNEL_ID  (k),
      .NUM_CHANNELS(NUM_CHANNELS)
    ) inst_copy_channel (
      .ap_clk    (ap_clk),
      .ap_rst_n  (ap_rst_n),
      .chan_rst_n(chan_rst_n),
      .job       (job),
      .wb_rsp    (chan_rsp[k]),
      .wb_req    (chan_req[k]),
      .done      (chan_done[k])
    );
  end

  // Single external master port
  wb_arbiter #(
    .NUM_CHANNELS(NUM_CHANNELS)
  ) inst_wb_arbiter (
    .ap_clk  (ap_clk),
    .ap_rst_n(ap_rst_n),
    .chan_req(chan_req),
    .port_rsp(wb_rsp),
    .chan_rsp(chan_rsp),
    .port_req(wb_req)
  );

endmodule

// File: tb_wb_memory.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Wishbone classic slave memory model
// Word-addressed RAM, filled from a Fibonacci LFSR at start-up. The
// same LFSR picks an extra wait of 0 to 3 cycles before each ack.
// ----------------------------------------------------------------------

module tb_wb_memory #(
  parameter int          DEPTH = 1024,
  parameter logic [31:0] SEED  = 32'h5848
) (
  input  logic                ap_clk,
  input  logic                ap_rst_n,
  input  kernel_pkg::wb_req_t wb_req,
  output kernel_pkg::wb_rsp_t wb_rsp
);

  import kernel_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [31:0]       lfsr;
  logic [1:0]        wait_cnt;   // Cycles left before ack
  logic              armed;      // Delay already drawn for this access
  logic [IDX_W-1:0]  word_idx;

  assign word_idx = wb_req.adr[IDX_W+1:2];  // Byte to word address

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  initial begin : fill
    logic [31:0] word;
    lfsr = SEED;
    for (int i = 0; i < DEPTH; i++) begin
      take_bits(32, word);
      mem[i] = word;
    end
  end

  // --------------------------------------------------------------------
  // Slave side, registered ack
  // --------------------------------------------------------------------
  always @(posedge ap_clk or negedge ap_rst_n) begin : slave
    logic [31:0] delay;
    logic [1:0]  cnt;
    if (!ap_rst_n) begin
      wb_rsp.ack <= 1'b0;
      wb_rsp.dat <= '0;
      wait_cnt   <= '0;
      armed      <= 1'b0;
    end else begin
      wb_rsp.ack <= 1'b0;
      if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
        if (!armed) begin
          take_bits(2, delay);  // New access, draw its wait
          cnt = delay[1:0];
        end else begin
          cnt = wait_cnt - 2'd1;
        end
        if (cnt == 2'd0) begin
          armed      <= 1'b0;
          wb_rsp.ack <= 1'b1;
          if (wb_req.we)
            mem[word_idx] = wb_req.dat;  // sel is always full
          else
            wb_rsp.dat <= mem[word_idx];
        end else begin
          armed    <= 1'b1;
          wait_cnt <= cnt;
        end
      end
    end
  end

endmodule

// File: tb_kernel_afu.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Copy kernel testbench
// Runs plain, swapped, zero-length and back-to-back jobs through the
// ap_ctrl_chain handshake and checks the whole memory after each one
// against a reference model of the copy.
// ----------------------------------------------------------------------

module tb_kernel_afu;

  import kernel_pkg::*;

  localparam int NUM_CHANNELS    = 4;
  localparam int PULSE_HOLD      = 8;
  localparam int DEPTH           = 1024;
  localparam int TOTAL_WORDS     = 8 + 37 + 20 + 0 + 12 + 16;  // All jobs
  localparam int WATCHDOG_CYCLES = 200 * TOTAL_WORDS + 2000;

  logic        ap_clk;
  logic        ap_rst_n;
  logic        ap_start;
  logic        ap_continue;
  descriptor_t descriptor;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        ap_idle;
  logic        ap_ready;
  logic        ap_done;

  logic [DATA_W-1:0] pre_mem [DEPTH];  // Memory before the job
  int    cur_src;                      // Current job, in words
  int    cur_dst;
  int    cur_count;
  logic  cur_swap;
  int    write_count;
  int    writes_before;
  int    ready_count;
  int    ready_edges;
  logic  check_pending;                // Hands the job to the checker
  int    errors;
  int    test_errs;
  int    tests_run;
  int    tests_failed;
  string test_name;

  always #2 ap_clk = ~ap_clk;  // 4 ns period

  kernel_afu #(
    .NUM_CHANNELS(NUM_CHANNELS),
    .PULSE_HOLD  (PULSE_HOLD)
  ) uut (
    .ap_clk     (ap_clk),
    .ap_rst_n   (ap_rst_n),
    .ap_start   (ap_start),
    .ap_continue(ap_continue),
    .descriptor (descriptor),
    .wb_rsp     (wb_rsp),
    .ap_idle    (ap_idle),
    .ap_ready   (ap_ready),
    .ap_done    (ap_done),
    .wb_req     (wb_req)
  );

  tb_wb_memory #(.DEPTH(DEPTH), .SEED(32'h5848)) mem_model (
    .ap_clk  (ap_clk),
    .ap_rst_n(ap_rst_n),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp)
  );

  // Bus and handshake monitors
  always @(posedge ap_clk) begin
    if (wb_req.cyc && wb_req.stb && wb_req.we && wb_rsp.ack)
      write_count++;
    if (wb_req.cyc && wb_req.stb && wb_rsp.ack && wb_req.sel !== {SEL_W{1'b1}}) begin
      $display("ERR @%0t: sel %b on a bus access", $time, wb_req.sel);
      note_error();
    end
    if (ap_ready)
      ready_count++;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
    abort_run("Watchdog expired before all tests finished");
  end

  // --------------------------------------------------------------------
  // Reference model and checker
  // --------------------------------------------------------------------
  // Expected word at a memory index after the current job
  function automatic logic [DATA_W-1:0] expected_word(input int idx);
    logic [DATA_W-1:0] w;
    if (idx >= cur_dst && idx < cur_dst + cur_count) begin
      w = pre_mem[cur_src + idx - cur_dst];
      if (cur_swap)
        w = {w[7:0], w[15:8], w[23:16], w[31:24]};  // Byte reversal
    end else begin
      w = pre_mem[idx];  // Outside the copy, untouched
    end
    return w;
  endfunction

  task automatic note_error();
    errors++;
    test_errs++;
  endtask

  always begin : compare_memory
    logic [DATA_W-1:0] exp;
    wait (check_pending);
    for (int i = 0; i < DEPTH; i++) begin
      exp = expected_word(i);
      if (mem_model.mem[i] !== exp) begin
        $display("ERR @%0t: word %0d expected %08h got %08h", $time, i, exp, mem_model.mem[i]);
        note_error();
      end
    end
    if (write_count - writes_before != cur_count) begin
      $display("ERR @%0t: %0d writes seen, %0d expected", $time,
               write_count - writes_before, cur_count);
      note_error();
    end
    check_pending = 1'b0;
  end

  // --------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%s at %0t", reason, $time);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  // Returns at the edge where ap_ready is seen
  task automatic wait_ready(input int limit, output int edges);
    edges = 1;
    @(posedge ap_clk);
    while (!ap_ready) begin
      if (edges > limit)
        abort_run("Timed out waiting for ap_ready");
      edges++;
      @(posedge ap_clk);
    end
  endtask

  task automatic wait_done(input int limit);
    int n;
    n = 0;
    @(posedge ap_clk);
    while (!ap_done) begin
      if (n > limit)
        abort_run("Timed out waiting for ap_done");
      n++;
      @(posedge ap_clk);
    end
  endtask

  // Called 1 ns after an edge, returns 1 ns after an edge
  task automatic run_job(input int src, input int dst, input int count,
                         input logic swap, input int hold, output int edges);
    int ready_before;
    int limit;
    limit = 200 * count + 100;
    for (int i = 0; i < DEPTH; i++)
      pre_mem[i] = mem_model.mem[i];
    cur_src       = src;
    cur_dst       = dst;
    cur_count     = count;
    cur_swap      = swap;
    writes_before = write_count;
    ready_before  = ready_count;
    descriptor.src_addr   = ADDR_W'(src * 4);
    descriptor.dst_addr   = ADDR_W'(dst * 4);
    descriptor.word_count = COUNT_W'(count);
    descriptor.swap_en    = swap;
    ap_start = 1'b1;
    wait_ready(limit, edges);  // Held through the reset pulse
    #1 ap_start = 1'b0;
    wait_done(limit);
    repeat (hold) begin
      @(posedge ap_clk);
      if (!ap_done) begin
        $display("ERR @%0t: ap_done fell before ap_continue", $time);
        note_error();
      end
    end
    #1 ap_continue = 1'b1;
    @(posedge ap_clk);
    #1 ap_continue = 1'b0;
    if (ap_done || !ap_idle) begin
      $display("ERR @%0t: ap_done %b ap_idle %b after ap_continue", $time, ap_done, ap_idle);
      note_error();
    end
    check_pending = 1'b1;
    wait (!check_pending);
    if (ready_count - ready_before != 1) begin
      $display("ERR @%0t: %0d ap_ready pulses", $time, ready_count - ready_before);
      note_error();
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs != 0)
      tests_failed++;
    $display("test %0d %s: %s (%0d errors)", tests_run, test_name,
             (test_errs == 0) ? "pass" : "FAIL", test_errs);
  endtask

  // --------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------
  initial begin
    ap_clk        = 1'b0;
    ap_rst_n      = 1'b0;
    ap_start      = 1'b0;
    ap_continue   = 1'b0;
    descriptor    = '0;
    check_pending = 1'b0;
    write_count   = 0;
    ready_count   = 0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (2) @(posedge ap_clk);

    begin_test("reset and handshake");
    if (!ap_idle || ap_done || ap_ready || wb_req.cyc || wb_req.stb) begin
      $display("ERR @%0t: outputs wrong in reset", $time);
      note_error();
    end
    #1 ap_rst_n = 1'b1;
    repeat (PULSE_HOLD + 4) @(posedge ap_clk);  // Power-up pulse drains
    #1;
    run_job(0, 512, 8, 1'b0, 0, ready_edges);
    if (ready_edges != 2) begin
      $display("ERR @%0t: ap_ready after %0d edges, expected 2", $time, ready_edges);
      note_error();
    end
    end_test();

    begin_test("plain copy of 37 words");
    run_job(100, 600, 37, 1'b0, 0, ready_edges);
    end_test();

    begin_test("swapped copy of 20 words");
    run_job(200, 700, 20, 1'b1, 0, ready_edges);
    end_test();

    begin_test("zero word count");
    run_job(300, 800, 0, 1'b0, 0, ready_edges);
    end_test();

    begin_test("held done then back-to-back job");
    run_job(320, 850, 12, 1'b0, 10, ready_edges);
    run_job(400, 900, 16, 1'b1, 0, ready_edges);  // Right after continue
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: kernel_afu.f
kernel_pkg.sv
kernel_control.sv
copy_channel.sv
wb_arbiter.sv
kernel_afu.sv
tb_wb_memory.sv
tb_kernel_afu.sv
